// File: verilog/pq_settings.svh
`ifndef PQ_SETTINGS_SVH
`define PQ_SETTINGS_SVH

// queue geometry
`define PQ_DEPTH 8     // slots, even and at least 4
`define PQ_PORTS 2     // ingress ports

// task word layout
`define PQ_DATA_W 16   // whole task word
`define PQ_PRIO_W 4    // priority field, top bits

`endif

// File: verilog/pq_pkg.sv
`include "pq_settings.svh"

package pq_pkg;

  // compared as one unsigned word, all-zero means empty slot
  typedef struct packed {
    logic [`PQ_PRIO_W-1:0]             prio;     // most significant
    logic                              src;      // ingress port id
    logic [`PQ_DATA_W-`PQ_PRIO_W-2:0]  payload;  // user data
  } task_t;

  // operation seen by the queue each cycle
  typedef enum logic [1:0] {
    OP_IDLE    = 2'd0,
    OP_PUSH    = 2'd1,
    OP_POP     = 2'd2,
    OP_REPLACE = 2'd3   // pop head and insert in one go
  } pq_op_e;

  // ingress staging register state
  typedef enum logic {
    ST_IDLE    = 1'b0,
    ST_PENDING = 1'b1
  } ingress_state_e;

endpackage

// File: verilog/register_array.sv
`timescale 1ns/1ps
`include "pq_settings.svh"

module register_array (
  input  var logic           i_CLK,    // clock
  input  var logic           i_RSTn,   // async reset, active low
  input  var pq_pkg::pq_op_e i_op,     // operation this cycle
  input  var pq_pkg::task_t  i_data,   // task to insert
  output var logic           o_full,   // all slots used
  output var logic           o_empty,  // no slot used
  output var pq_pkg::task_t  o_head    // largest stored task
);

  localparam int DEPTH = `PQ_DEPTH;
  localparam int PAIRS = DEPTH / 2;
  localparam int CNT_W = $clog2(DEPTH) + 1;

  pq_pkg::task_t slot    [DEPTH];  // registered slots
  pq_pkg::task_t shifted [DEPTH];  // after head operation
  pq_pkg::task_t sorted  [DEPTH];  // after both sort stages
  pq_pkg::task_t pair_hi [PAIRS];
  pq_pkg::task_t pair_lo [PAIRS];

  logic [CNT_W-1:0] size;
  logic [CNT_W-1:0] size_nxt;
  logic             full;
  logic             empty;

  assign full    = (size == CNT_W'(DEPTH));
  assign empty   = (size == '0);
  assign o_full  = full;
  assign o_empty = empty;
  assign o_head  = slot[0];

  // occupancy count
  always_comb begin
    case (i_op)
      pq_pkg::OP_PUSH: size_nxt = full ? size : size + 1'b1;
      pq_pkg::OP_POP:  size_nxt = empty ? size : size - 1'b1;
      pq_pkg::OP_REPLACE: begin
        if (empty && i_data != '0) begin
          size_nxt = size + 1'b1;   // replace into empty acts as push
        end else if (!empty && i_data == '0) begin
          size_nxt = size - 1'b1;   // replace with zero acts as pop
        end else begin
          size_nxt = size;
        end
      end
      default: size_nxt = size;
    endcase
  end

  // head operation
  always_comb begin
    shifted = slot;
    case (i_op)
      pq_pkg::OP_PUSH: begin
        if (!full) begin
          for (int i = DEPTH - 1; i > 0; i--) begin
            shifted[i] = slot[i-1];   // make room at the head
          end
          shifted[0] = i_data;
        end
      end
      pq_pkg::OP_POP: begin
        for (int i = 0; i < DEPTH - 1; i++) begin
          shifted[i] = slot[i+1];   // close the gap left by the head
        end
        shifted[DEPTH-1] = '0;
      end
      pq_pkg::OP_REPLACE: shifted[0] = i_data;
      default: ;
    endcase
  end

  // pairwise min/max stage
  always_comb begin
    for (int i = 0; i < PAIRS; i++) begin
      if (shifted[2*i] > shifted[2*i+1]) begin
        pair_hi[i] = shifted[2*i];
        pair_lo[i] = shifted[2*i+1];
      end else begin
        pair_hi[i] = shifted[2*i+1];
        pair_lo[i] = shifted[2*i];
      end
    end
  end

  // odd-even exchange between neighbouring pairs
  always_comb begin
    sorted[0] = pair_hi[0];   // head is always the maximum
    for (int i = 0; i < PAIRS - 1; i++) begin
      if (pair_lo[i] > pair_hi[i+1]) begin
        sorted[2*i+1] = pair_lo[i];
        sorted[2*i+2] = pair_hi[i+1];
      end else begin
        sorted[2*i+1] = pair_hi[i+1];
        sorted[2*i+2] = pair_lo[i];
      end
    end
    sorted[DEPTH-1] = pair_lo[PAIRS-1];
  end

  always_ff @(posedge i_CLK or negedge i_RSTn) begin
    if (!i_RSTn) begin
      slot <= '{default: '0};   // zero word marks an empty slot
      size <= '0;
    end else begin
      slot <= sorted;
      size <= size_nxt;
    end
  end

endmodule

// File: verilog/ingress_port.sv
`timescale 1ns/1ps
`include "pq_settings.svh"

module ingress_port #(
  parameter int unsigned PORT_ID = 0   // written into the src field
) (
  input  var logic                             i_CLK,
  input  var logic                             i_RSTn,
  input  var logic                             i_valid,    // one-cycle strobe
  input  var logic [`PQ_PRIO_W-1:0]            i_prio,
  input  var logic [`PQ_DATA_W-`PQ_PRIO_W-2:0] i_payload,
  input  var logic                             i_grant,    // from arbiter
  output var logic                             o_req,      // task waiting
  output var pq_pkg::task_t                    o_task,     // staged task
  output var logic                             o_busy,     // cannot take a strobe
  output var logic                             o_drop      // strobe was discarded
);

  pq_pkg::ingress_state_e state;
  pq_pkg::ingress_state_e state_nxt;
  pq_pkg::task_t          task_q;
  logic                   accept;
  logic                   drop_q;

  // priority 0 is the empty-slot code, never stored
  assign accept = i_valid && (i_prio != '0) && (state == pq_pkg::ST_IDLE);

  always_comb begin
    state_nxt = state;
    case (state)
      pq_pkg::ST_IDLE:    if (accept) state_nxt = pq_pkg::ST_PENDING;
      pq_pkg::ST_PENDING: if (i_grant) state_nxt = pq_pkg::ST_IDLE;
      default:            state_nxt = pq_pkg::ST_IDLE;
    endcase
  end

  always_ff @(posedge i_CLK or negedge i_RSTn) begin
    if (!i_RSTn) begin
      state  <= pq_pkg::ST_IDLE;
      drop_q <= 1'b0;
    end else begin
      state  <= state_nxt;
      drop_q <= i_valid && !accept;   // one pulse per lost strobe
    end
  end

  always_ff @(posedge i_CLK) begin
    if (accept) begin
      task_q.prio    <= i_prio;
      task_q.src     <= 1'(PORT_ID);   // tag with own port
      task_q.payload <= i_payload;
    end
  end

  assign o_req  = (state == pq_pkg::ST_PENDING);
  assign o_busy = (state == pq_pkg::ST_PENDING);
  assign o_task = task_q;
  assign o_drop = drop_q;

endmodule

// File: verilog/push_arbiter.sv
`timescale 1ns/1ps
`include "pq_settings.svh"

module push_arbiter (
  input  var logic                 i_CLK,
  input  var logic                 i_RSTn,
  input  var logic [`PQ_PORTS-1:0] i_req,                // per-port request
  input  var pq_pkg::task_t        i_task [`PQ_PORTS],   // per-port staged task
  input  var logic                 i_full,               // queue full
  input  var logic                 i_pop_req,            // qualified pop
  output var logic [`PQ_PORTS-1:0] o_grant,              // one-hot or zero
  output var pq_pkg::pq_op_e       o_op,
  output var pq_pkg::task_t        o_push_task
);

  localparam int PORTS = `PQ_PORTS;
  localparam int PTR_W = (PORTS > 1) ? $clog2(PORTS) : 1;

  logic [PTR_W-1:0] last;       // last served port
  logic [PTR_W-1:0] pick;
  logic             found;
  logic             can_push;

  // search starts one past the last served port
  always_comb begin
    int idx;
    found = 1'b0;
    pick  = last;
    for (int off = 1; off <= PORTS; off++) begin
      idx = (int'(last) + off) % PORTS;
      if (!found && i_req[idx]) begin
        found = 1'b1;
        pick  = PTR_W'(idx);
      end
    end
  end

  // full queue only takes a task when the head leaves at the same time
  assign can_push    = found && (!i_full || i_pop_req);
  assign o_grant     = can_push ? (PORTS'(1) << pick) : '0;
  assign o_push_task = can_push ? i_task[pick] : '0;

  always_comb begin
    case ({can_push, i_pop_req})
      2'b11:   o_op = pq_pkg::OP_REPLACE;
      2'b10:   o_op = pq_pkg::OP_PUSH;
      2'b01:   o_op = pq_pkg::OP_POP;
      default: o_op = pq_pkg::OP_IDLE;
    endcase
  end

  always_ff @(posedge i_CLK or negedge i_RSTn) begin
    if (!i_RSTn) begin
      last <= PTR_W'(PORTS - 1);   // port 0 goes first
    end else if (can_push) begin
      last <= pick;
    end
  end

endmodule

// File: verilog/pop_control.sv
`timescale 1ns/1ps

module pop_control (
  input  var logic          i_CLK,
  input  var logic          i_RSTn,
  input  var logic          i_pop,         // consumer wants a task
  input  var logic          i_empty,       // queue empty
  input  var pq_pkg::task_t i_head,        // current queue head
  output var logic          o_pop_req,     // to arbiter
  output var logic          o_task_valid,  // one-cycle pulse
  output var pq_pkg::task_t o_task         // delivered task
);

  logic          valid_q;
  pq_pkg::task_t task_q;

  // a pop on an empty queue is ignored
  assign o_pop_req = i_pop && !i_empty;

  always_ff @(posedge i_CLK or negedge i_RSTn) begin
    if (!i_RSTn) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= o_pop_req;
    end
  end

  // capture head before the queue moves it out
  always_ff @(posedge i_CLK) begin
    if (o_pop_req) begin
      task_q <= i_head;
    end
  end

  assign o_task_valid = valid_q;
  assign o_task       = task_q;

endmodule

// File: verilog/task_scheduler_top.sv
`timescale 1ns/1ps
`include "pq_settings.svh"

module task_scheduler_top (
  input  var logic                             i_CLK,
  input  var logic                             i_RSTn,
  input  var logic [`PQ_PORTS-1:0]             i_src_valid,
  input  var logic [`PQ_PRIO_W-1:0]            i_src_prio    [`PQ_PORTS],
  input  var logic [`PQ_DATA_W-`PQ_PRIO_W-2:0] i_src_payload [`PQ_PORTS],
  input  var logic                             i_pop,
  output var logic [`PQ_PORTS-1:0]             o_busy,
  output var logic [`PQ_PORTS-1:0]             o_drop,
  output var logic                             o_task_valid,
  output var pq_pkg::task_t                    o_task,
  output var logic                             o_full,
  output var logic                             o_empty
);

  logic [`PQ_PORTS-1:0] port_req;
  logic [`PQ_PORTS-1:0] port_grant;
  pq_pkg::task_t        port_task [`PQ_PORTS];
  pq_pkg::pq_op_e       queue_op;
  pq_pkg::task_t        push_task;
  pq_pkg::task_t        queue_head;
  logic                 pop_req;

  for (genvar p = 0; p < `PQ_PORTS; p++) begin : g_port
    ingress_port #(.PORT_ID(p)) u_ingress (
      .i_CLK     (i_CLK),
      .i_RSTn    (i_RSTn),
      .i_valid   (i_src_valid[p]),
      .i_prio    (i_src_prio[p]),
      .i_payload (i_src_payload[p]),
      .i_grant   (port_grant[p]),
      .o_req     (port_req[p]),
      .o_task    (port_task[p]),
      .o_busy    (o_busy[p]),
      .o_drop    (o_drop[p])
    );
  end

  push_arbiter u_arbiter (
    .i_CLK       (i_CLK),
    .i_RSTn      (i_RSTn),
    .i_req       (port_req),
    .i_task      (port_task),
    .i_full      (o_full),
    .i_pop_req   (pop_req),
    .o_grant     (port_grant),
    .o_op        (queue_op),
    .o_push_task (push_task)
  );

  register_array u_queue (
    .i_CLK   (i_CLK),
    .i_RSTn  (i_RSTn),
    .i_op    (queue_op),
    .i_data  (push_task),
    .o_full  (o_full),
    .o_empty (o_empty),
    .o_head  (queue_head)
  );

  pop_control u_pop (
    .i_CLK        (i_CLK),
    .i_RSTn       (i_RSTn),
    .i_pop        (i_pop),
    .i_empty      (o_empty),
    .i_head       (queue_head),
    .o_pop_req    (pop_req),
    .o_task_valid (o_task_valid),
    .o_task       (o_task)
  );

endmodule

// File: verif/tb_task_scheduler.sv
`timescale 1ns/1ps
`include "pq_settings.svh"

module tb_task_scheduler;

  localparam int  PORTS      = `PQ_PORTS;
  localparam int  DEPTH      = `PQ_DEPTH;
  localparam int  DATA_W     = `PQ_DATA_W;
  localparam int  PRIO_W     = `PQ_PRIO_W;
  localparam int  PAY_W      = DATA_W - PRIO_W - 1;
  localparam int  N_CYCLES   = 3000;
  localparam int  PHASE_LEN  = 500;   // cycles per pop-rate phase
  localparam int  DRAIN_MAX  = 40;
  localparam real CLK_PERIOD = 8.0;

  logic              i_CLK;
  logic              i_RSTn;
  logic [PORTS-1:0]  i_src_valid;
  logic [PRIO_W-1:0] i_src_prio    [PORTS];
  logic [PAY_W-1:0]  i_src_payload [PORTS];
  logic              i_pop;
  logic [PORTS-1:0]  o_busy;
  logic [PORTS-1:0]  o_drop;
  logic              o_task_valid;
  pq_pkg::task_t     o_task;
  logic              o_full;
  logic              o_empty;

  // reference model state
  logic [PORTS-1:0]  m_pending;
  logic [DATA_W-1:0] m_task [PORTS];
  logic [PORTS-1:0]  m_drop;
  int                m_last;           // last served port
  logic [DATA_W-1:0] m_queue [$];      // queued tasks, unordered
  logic              m_valid;
  logic [DATA_W-1:0] m_out;

  int                seed;
  int                errors;
  int                checks;
  int                n_pops;
  int                n_drops;
  int                n_replaces;
  int                n_full;
  int                drain;
  logic              ordered;          // no more pushes can happen
  logic [DATA_W-1:0] prev_out;

  task_scheduler_top i_task_scheduler_top (
    .i_CLK         (i_CLK),
    .i_RSTn        (i_RSTn),
    .i_src_valid   (i_src_valid),
    .i_src_prio    (i_src_prio),
    .i_src_payload (i_src_payload),
    .i_pop         (i_pop),
    .o_busy        (o_busy),
    .o_drop        (o_drop),
    .o_task_valid  (o_task_valid),
    .o_task        (o_task),
    .o_full        (o_full),
    .o_empty       (o_empty)
  );

  initial begin
    i_CLK = 1'b0;
    forever #(CLK_PERIOD / 2) i_CLK = ~i_CLK;
  end

  task automatic check_value(string name, logic [15:0] got, logic [15:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("[ERROR] %0t %s got %0h expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic check_outputs();
    check_value("o_full", 16'(o_full), 16'(m_queue.size() == DEPTH));
    check_value("o_empty", 16'(o_empty), 16'(m_queue.size() == 0));
    check_value("o_busy", 16'(o_busy), 16'(m_pending));
    check_value("o_drop", 16'(o_drop), 16'(m_drop));
    check_value("o_task_valid", 16'(o_task_valid), 16'(m_valid));
    if (m_valid) begin
      check_value("o_task", 16'(o_task), m_out);
      if (ordered) begin
        assert (16'(o_task) <= prev_out) else begin
          errors++;
          $display("[ERROR] %0t o_task got %0h expected at most %0h",
                   $time, o_task, prev_out);
        end
        prev_out = 16'(o_task);
      end
    end
  endtask

  // low pop rate in even phases lets the queue fill up
  task automatic drive_random(int cyc);
    logic [31:0] r;
    logic [3:0]  pop_thresh;
    pop_thresh = ((cyc / PHASE_LEN) % 2 == 0) ? 4'd2 : 4'd9;
    for (int p = 0; p < PORTS; p++) begin
      r = $random(seed);
      i_src_valid[p]   = r[0];
      i_src_prio[p]    = PRIO_W'(r >> 8);    // zero now and then
      i_src_payload[p] = PAY_W'(r >> 12);
    end
    r = $random(seed);
    i_pop = (r[7:4] < pop_thresh);
  endtask

  // one clock edge of the scheduler rules, from the inputs now applied
  task automatic model_step();
    logic             full;
    logic             empty;
    logic             pop_req;
    logic             found;
    logic [PORTS-1:0] grant;
    logic             accept;
    int               pick;
    int               idx;
    int               hi;
    full    = (m_queue.size() == DEPTH);
    empty   = (m_queue.size() == 0);
    pop_req = i_pop && !empty;
    found   = 1'b0;
    pick    = 0;
    grant   = '0;
    for (int off = 1; off <= PORTS; off++) begin
      idx = (m_last + off) % PORTS;   // round robin after last served
      if (!found && m_pending[idx]) begin
        found = 1'b1;
        pick  = idx;
      end
    end
    if (found && (!full || pop_req)) begin
      grant[pick] = 1'b1;
      m_last      = pick;
    end
    if (full) n_full++;
    m_valid = pop_req;
    if (pop_req) begin
      hi = 0;
      for (int i = 1; i < m_queue.size(); i++) begin
        if (m_queue[i] > m_queue[hi]) hi = i;
      end
      m_out = m_queue[hi];
      m_queue.delete(hi);
      n_pops++;
      if (grant != '0) n_replaces++;
    end
    if (grant != '0) m_queue.push_back(m_task[pick]);
    for (int p = 0; p < PORTS; p++) begin
      accept    = i_src_valid[p] && (i_src_prio[p] != '0) && !m_pending[p];
      m_drop[p] = i_src_valid[p] && !accept;
      if (m_drop[p]) n_drops++;
      if (accept) begin
        m_pending[p] = 1'b1;
        m_task[p]    = {i_src_prio[p], 1'(p), i_src_payload[p]};
      end else if (grant[p]) begin
        m_pending[p] = 1'b0;
      end
    end
  endtask

  initial begin
    seed       = 32'h4c62cfde;
    errors     = 0;
    checks     = 0;
    n_pops     = 0;
    n_drops    = 0;
    n_replaces = 0;
    n_full     = 0;
    ordered    = 1'b0;
    prev_out   = '1;
    i_RSTn      = 1'b0;
    i_src_valid = '0;
    i_pop       = 1'b0;
    for (int p = 0; p < PORTS; p++) begin
      i_src_prio[p]    = '0;
      i_src_payload[p] = '0;
    end
    m_pending = '0;
    m_drop    = '0;
    m_last    = PORTS - 1;   // port 0 favored first
    m_valid   = 1'b0;
    m_out     = '0;

    repeat (4) @(posedge i_CLK);
    @(negedge i_CLK);
    i_RSTn = 1'b1;

    for (int cyc = 0; cyc < N_CYCLES; cyc++) begin
      check_outputs();
      drive_random(cyc);
      model_step();
      @(negedge i_CLK);
    end

    // drain with no new strobes, pending tasks still enter first
    drain = 0;
    while ((m_queue.size() != 0 || m_pending != '0 || m_valid) && drain < DRAIN_MAX) begin
      check_outputs();
      i_src_valid = '0;
      i_pop       = 1'b1;
      if (m_pending == '0) ordered = 1'b1;
      model_step();
      @(negedge i_CLK);
      drain++;
    end
    check_outputs();
    assert (o_empty && o_busy == '0) else begin
      errors++;
      $display("queue still held tasks after %0d drain cycles", drain);
    end

    $display("checks=%0d errors=%0d pops=%0d drops=%0d replaces=%0d full_cycles=%0d",
             checks, errors, n_pops, n_drops, n_replaces, n_full);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  initial begin
    #((N_CYCLES + 100) * CLK_PERIOD);
    $display("watchdog expired before the test sequence finished");
    $display("Regression failed");
    $finish;
  end

endmodule

// File: build.f
+incdir+verilog
verilog/pq_pkg.sv
verilog/register_array.sv
verilog/ingress_port.sv
verilog/push_arbiter.sv
verilog/pop_control.sv
verilog/task_scheduler_top.sv
verif/tb_task_scheduler.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := tb_task_scheduler
FILELIST   := build.f
OBJ_DIR    := obj_dir
FLAGS      := --binary --timing --assert --timescale 1ns/1ps -j 0
LINT_FLAGS := --lint-only --timing -Wall
PASS_MSG   := Regression passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
